// File: project.f
rtl/bch_pkg.sv
rtl/bch_syndrome_unit.sv
rtl/bch_locator_solver.sv
rtl/bch_chien_search.sv
rtl/bch_decode_sequencer.sv
rtl/bch_decoder.sv
verification/tb_clock_gen.sv
verification/tb_bch_decoder.sv

// File: rtl/bch_chien_search.sv
`timescale 1ns/1ps
`default_nettype none

module bch_chien_search (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  bch_pkg::locator_t    locator,
    output logic                 done,
    output bch_pkg::codeword_t   error_pattern,
    output bch_pkg::err_count_t  root_count
);

    logic              busy;
    logic [3:0]        pos;
    bch_pkg::gf_elem_t x_pow;    // alpha^pos
    bch_pkg::gf_elem_t x_eval;
    bch_pkg::gf_elem_t poly_val;
    logic              root_hit;

    // position 0 is tested on the start edge with X = 1
    always_comb begin
        x_eval = busy ? x_pow : 4'b0001;
        case (locator.degree)
            2'd2: poly_val = bch_pkg::gf_mul(x_eval, x_eval)
                             ^ bch_pkg::gf_mul(locator.sigma1, x_eval)
                             ^ locator.sigma2;
            2'd1: poly_val = x_eval ^ locator.sigma1;
            default: poly_val = x_eval;   // powers of alpha are never zero
        endcase
        root_hit = (poly_val == '0);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            pos  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                pos  <= 4'd1;
            end else if (busy) begin
                if (pos == 4'(bch_pkg::CODE_LEN - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    pos <= pos + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x_pow         <= bch_pkg::ALPHA;
            error_pattern <= bch_pkg::codeword_t'(root_hit);
            root_count    <= {1'b0, root_hit};
        end else if (busy) begin
            x_pow <= bch_pkg::gf_mul(x_pow, bch_pkg::ALPHA);
            if (root_hit) begin
                error_pattern[pos] <= 1'b1;
                if (root_count != 2'd3) begin
                    root_count <= root_count + 2'd1;   // saturates
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/bch_decode_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bch_decode_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  bch_pkg::codeword_t      codeword_in,
    output logic                    ack,
    output bch_pkg::decode_result_t result,
    output logic                    syn_start,
    input  logic                    syn_done,
    output logic                    solve_start,
    input  logic                    solve_done,
    input  bch_pkg::locator_t       locator,
    output logic                    chien_start,
    input  logic                    chien_done,
    input  bch_pkg::codeword_t      error_pattern,
    input  bch_pkg::err_count_t     root_count,
    output bch_pkg::codeword_t      latched_word
);

    bch_pkg::seq_state_t state;

    always_ff @(posedge clk) begin
        if (state == bch_pkg::st_idle && req) begin
            latched_word <= codeword_in;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= bch_pkg::st_idle;
            ack         <= 1'b0;
            result      <= '0;
            syn_start   <= 1'b0;
            solve_start <= 1'b0;
            chien_start <= 1'b0;
        end else begin
            syn_start   <= 1'b0;
            solve_start <= 1'b0;
            chien_start <= 1'b0;
            case (state)
                bch_pkg::st_idle: if (req) begin
                    syn_start <= 1'b1;
                    state     <= bch_pkg::st_syndrome;
                end
                bch_pkg::st_syndrome: if (syn_done) begin
                    solve_start <= 1'b1;
                    state       <= bch_pkg::st_solve;
                end
                bch_pkg::st_solve: if (solve_done) begin
                    if (locator.fail || locator.degree == 2'd0) begin
                        // nothing to search, word goes back as received
                        result.codeword      <= latched_word;
                        result.error_count   <= 2'd0;
                        result.uncorrectable <= locator.fail;
                        ack                  <= 1'b1;
                        state                <= bch_pkg::st_respond;
                    end else begin
                        chien_start <= 1'b1;
                        state       <= bch_pkg::st_search;
                    end
                end
                bch_pkg::st_search: if (chien_done) begin
                    if (root_count != locator.degree) begin
                        result.codeword      <= latched_word;
                        result.error_count   <= 2'd0;
                        result.uncorrectable <= 1'b1;   // locator roots outside the field
                    end else begin
                        result.codeword      <= latched_word ^ error_pattern;
                        result.error_count   <= locator.degree;
                        result.uncorrectable <= 1'b0;
                    end
                    ack   <= 1'b1;
                    state <= bch_pkg::st_respond;
                end
                bch_pkg::st_respond: if (!req) begin
                    ack   <= 1'b0;
                    state <= bch_pkg::st_release;
                end
                bch_pkg::st_release: state <= bch_pkg::st_idle;   // ack is low here
                default: state <= bch_pkg::st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/bch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bch_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  bch_pkg::codeword_t      codeword_in,
    output logic                    ack,
    output bch_pkg::decode_result_t result
);

    logic                    syn_start;
    logic                    syn_done;
    logic                    solve_start;
    logic                    solve_done;
    logic                    chien_start;
    logic                    chien_done;
    bch_pkg::syndrome_pair_t syndromes;
    bch_pkg::locator_t       locator;
    bch_pkg::codeword_t      error_pattern;
    bch_pkg::err_count_t     root_count;
    bch_pkg::codeword_t      latched_word;

    bch_decode_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .codeword_in   (codeword_in),
        .ack           (ack),
        .result        (result),
        .syn_start     (syn_start),
        .syn_done      (syn_done),
        .solve_start   (solve_start),
        .solve_done    (solve_done),
        .locator       (locator),
        .chien_start   (chien_start),
        .chien_done    (chien_done),
        .error_pattern (error_pattern),
        .root_count    (root_count),
        .latched_word  (latched_word)
    );

    bch_syndrome_unit u_syndrome (
        .clk       (clk),
        .rst       (rst),
        .start     (syn_start),
        .codeword  (latched_word),
        .done      (syn_done),
        .syndromes (syndromes)
    );

    bch_locator_solver u_solver (
        .clk       (clk),
        .rst       (rst),
        .start     (solve_start),
        .syndromes (syndromes),
        .done      (solve_done),
        .locator   (locator)
    );

    bch_chien_search u_chien (
        .clk           (clk),
        .rst           (rst),
        .start         (chien_start),
        .locator       (locator),
        .done          (chien_done),
        .error_pattern (error_pattern),
        .root_count    (root_count)
    );

endmodule

`default_nettype wire

// File: rtl/bch_locator_solver.sv
`timescale 1ns/1ps
`default_nettype none

module bch_locator_solver (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  bch_pkg::syndrome_pair_t syndromes,
    output logic                    done,
    output bch_pkg::locator_t       locator
);

    logic                    stage2;
    bch_pkg::syndrome_pair_t syn_q;
    bch_pkg::gf_elem_t       s1_cube;
    bch_pkg::gf_elem_t       s1_inv;

    // first cycle, cube and inverse of S1
    always_ff @(posedge clk) begin
        if (start) begin
            syn_q   <= syndromes;
            s1_cube <= bch_pkg::gf_cube(syndromes.s1);
            s1_inv  <= bch_pkg::gf_inv(syndromes.s1);
        end
    end

    // second cycle, closed-form peterson case split
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage2  <= 1'b0;
            done    <= 1'b0;
            locator <= '0;
        end else begin
            done   <= 1'b0;
            stage2 <= start;
            if (stage2) begin
                done           <= 1'b1;
                locator.sigma1 <= syn_q.s1;
                locator.sigma2 <= '0;
                locator.fail   <= 1'b0;
                if (syn_q.s1 == '0) begin
                    locator.degree <= 2'd0;
                    locator.fail   <= (syn_q.s3 != '0);   // not a t<=2 pattern
                end else if (syn_q.s3 == s1_cube) begin
                    locator.degree <= 2'd1;
                end else begin
                    locator.degree <= 2'd2;
                    // sigma2 = (S3 + S1^3) / S1
                    locator.sigma2 <= bch_pkg::gf_mul(syn_q.s3 ^ s1_cube, s1_inv);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/bch_pkg.sv
`default_nettype none

package bch_pkg;

    localparam int CODE_LEN = 15;

    typedef logic [3:0]          gf_elem_t;    // GF(16), polynomial basis
    typedef logic [CODE_LEN-1:0] codeword_t;   // bit i is coefficient of x^i
    typedef logic [1:0]          err_count_t;

    localparam gf_elem_t ALPHA  = 4'b0010;
    localparam gf_elem_t ALPHA3 = 4'b1000;

    typedef struct packed {
        gf_elem_t s1;
        gf_elem_t s3;
    } syndrome_pair_t;

    typedef struct packed {
        gf_elem_t   sigma1;
        gf_elem_t   sigma2;
        err_count_t degree;
        logic       fail;      // S1 zero with S3 nonzero
    } locator_t;

    typedef struct packed {
        codeword_t  codeword;
        err_count_t error_count;
        logic       uncorrectable;
    } decode_result_t;

    typedef enum logic [2:0] {
        st_idle,
        st_syndrome,
        st_solve,
        st_search,
        st_respond,
        st_release
    } seq_state_t;

    // carry-less product, then fold back with x^4 = x + 1
    function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
        logic [6:0] prod;
        prod = '0;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                prod = prod ^ (7'(a) << i);
            end
        end
        for (int k = 6; k >= 4; k--) begin
            if (prod[k]) begin
                prod = prod ^ (7'b0010011 << (k - 4));
            end
        end
        return prod[3:0];
    endfunction

    // inverse of alpha^i is alpha^(15-i), zero maps to zero
    function automatic gf_elem_t gf_inv(input gf_elem_t a);
        gf_elem_t inv;
        case (a)
            4'h1: inv = 4'h1;
            4'h2: inv = 4'h9;
            4'h3: inv = 4'he;
            4'h4: inv = 4'hd;
            4'h5: inv = 4'hb;
            4'h6: inv = 4'h7;
            4'h7: inv = 4'h6;
            4'h8: inv = 4'hf;
            4'h9: inv = 4'h2;
            4'ha: inv = 4'hc;
            4'hb: inv = 4'h5;
            4'hc: inv = 4'ha;
            4'hd: inv = 4'h4;
            4'he: inv = 4'h3;
            4'hf: inv = 4'h8;
            default: inv = 4'h0;
        endcase
        return inv;
    endfunction

    function automatic gf_elem_t gf_cube(input gf_elem_t a);
        return gf_mul(a, gf_mul(a, a));
    endfunction

endpackage

`default_nettype wire

// File: rtl/bch_syndrome_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  bch_pkg::codeword_t      codeword,
    output logic                    done,
    output bch_pkg::syndrome_pair_t syndromes
);

    logic             busy;
    logic [3:0]       pos;     // next bit to fold in
    bch_pkg::gf_elem_t s1_acc;
    bch_pkg::gf_elem_t s3_acc;

    // pass control, bit 14 is taken on the start edge itself
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            pos  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                pos  <= 4'(bch_pkg::CODE_LEN - 2);
            end else if (busy) begin
                if (pos == 4'd0) begin
                    busy <= 1'b0;
                    done <= 1'b1;   // bit 0 folded this edge
                end else begin
                    pos <= pos - 4'd1;
                end
            end
        end
    end

    // horner accumulators, S1 at alpha and S3 at alpha^3
    always_ff @(posedge clk) begin
        if (start) begin
            s1_acc <= {3'b000, codeword[bch_pkg::CODE_LEN-1]};
            s3_acc <= {3'b000, codeword[bch_pkg::CODE_LEN-1]};
        end else if (busy) begin
            s1_acc <= bch_pkg::gf_mul(s1_acc, bch_pkg::ALPHA) ^ {3'b000, codeword[pos]};
            s3_acc <= bch_pkg::gf_mul(s3_acc, bch_pkg::ALPHA3) ^ {3'b000, codeword[pos]};
        end
    end

    assign syndromes.s1 = s1_acc;
    assign syndromes.s3 = s3_acc;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds and runs the BCH(15,7) decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_bch_decoder \
    -f project.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q ">>> PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: verification/tb_bch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bch_decoder;

    localparam int WORDS_PER_TEST = 50;
    localparam int TOTAL_WORDS    = 4 * WORDS_PER_TEST;
    localparam int CYCLE_LIMIT    = TOTAL_WORDS * 40 + 100;
    localparam logic [8:0] GEN_POLY = 9'h1d1;   // x^8 + x^7 + x^6 + x^4 + 1

    logic                    clk;
    logic                    rst;
    logic                    req;
    bch_pkg::codeword_t      codeword_in;
    logic                    ack;
    bch_pkg::decode_result_t result;

    int                      errors;
    int                      hs_errors;   // handshake monitor failures
    int                      checks;
    int                      cycles;
    int                      release_wait;
    logic                    ack_q;
    logic                    rst_q;
    bch_pkg::decode_result_t result_q;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    bch_decoder dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .codeword_in (codeword_in),
        .ack         (ack),
        .result      (result)
    );

    // long division by g(x), bits 14..8 are folded away
    function automatic logic [7:0] gen_remainder(input bch_pkg::codeword_t word);
        bch_pkg::codeword_t w;
        w = word;
        for (int k = 14; k >= 8; k--) begin
            if (w[k]) begin
                w = w ^ (15'(GEN_POLY) << (k - 8));
            end
        end
        return w[7:0];
    endfunction

    // systematic, message in bits 14..8
    function automatic bch_pkg::codeword_t encode_message(input logic [6:0] msg);
        bch_pkg::codeword_t shifted;
        shifted = {msg, 8'h00};
        return shifted | {7'h00, gen_remainder(shifted)};
    endfunction

    function automatic int count_ones(input bch_pkg::codeword_t w);
        int n;
        n = 0;
        for (int i = 0; i < 15; i++) begin
            if (w[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // nerr distinct random positions
    function automatic bch_pkg::codeword_t error_mask(input int nerr);
        bch_pkg::codeword_t mask;
        int                 pos;
        mask = '0;
        while (count_ones(mask) < nerr) begin
            pos  = int'($urandom % 15);
            mask = mask | (15'd1 << pos);
        end
        return mask;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("ERROR %s expected 0x%0h got 0x%0h", name, expected, actual);
    endtask

    // one full four-phase transaction
    task automatic run_word(input bch_pkg::codeword_t word,
                            output bch_pkg::decode_result_t res);
        int hold;
        @(posedge clk);
        req         <= 1'b1;
        codeword_in <= word;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        res  = result;
        hold = int'($urandom % 6);   // extra cycles with req still high
        repeat (hold) @(posedge clk);
        @(posedge clk);
        req         <= 1'b0;
        codeword_in <= 15'($urandom);   // decoder must have latched the word
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic run_test(input int test_id, input int nerr, input string label);
        bch_pkg::codeword_t      sent;
        bch_pkg::codeword_t      received;
        bch_pkg::decode_result_t res;
        int                      errors_before;
        errors_before = errors;
        for (int w = 0; w < WORDS_PER_TEST; w++) begin
            sent     = encode_message(7'($urandom));
            received = sent ^ error_mask(nerr);
            run_word(received, res);
            checks++;
            if (nerr <= 2) begin
                if (res.codeword != sent) begin
                    report_mismatch("result.codeword", 32'(sent), 32'(res.codeword));
                end
                if (res.error_count != 2'(nerr)) begin
                    report_mismatch("result.error_count", 32'(nerr), 32'(res.error_count));
                end
                if (res.uncorrectable) begin
                    report_mismatch("result.uncorrectable", 32'd0, 32'd1);
                end
            end else if (res.uncorrectable) begin
                if (res.codeword != received) begin
                    report_mismatch("result.codeword", 32'(received), 32'(res.codeword));
                end
                if (res.error_count != 2'd0) begin
                    report_mismatch("result.error_count", 32'd0, 32'(res.error_count));
                end
            end else begin
                // miscorrection onto some other codeword
                if (gen_remainder(res.codeword) != 8'h00) begin
                    errors++;
                    $display("corrected word 0x%0h is not a valid codeword", res.codeword);
                end
                if (res.error_count == 2'd0 || res.error_count == 2'd3) begin
                    errors++;
                    $display("decoder claims a correction with error_count %0d",
                             res.error_count);
                end
                if (count_ones(res.codeword ^ received) != int'(res.error_count)) begin
                    report_mismatch("flipped bit count",
                                    32'(res.error_count),
                                    32'(count_ones(res.codeword ^ received)));
                end
            end
        end
        $display("test %0d %s: %0d words, %0d errors", test_id, label, WORDS_PER_TEST,
                 errors - errors_before);
    endtask

    // handshake monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst || rst_q) begin
            if (ack) begin
                hs_errors++;
                $display("ack is high during or just after reset");
            end
        end else begin
            if (ack && !ack_q && !req) begin
                hs_errors++;
                $display("ack rose while req was low");
            end
            if (ack && !req) begin
                release_wait++;
                if (release_wait == 3) begin
                    hs_errors++;
                    $display("ack did not fall after req fell");
                end
            end else begin
                release_wait = 0;
            end
            if (ack && ack_q && result != result_q) begin
                hs_errors++;
                $display("ERROR result expected 0x%0h got 0x%0h", result_q, result);
            end
        end
        ack_q    = ack;
        rst_q    = rst;
        result_q = result;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the decoder stopped answering", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h0f587c93));
        req          = 1'b0;
        codeword_in  = '0;
        errors       = 0;
        hs_errors    = 0;
        checks       = 0;
        cycles       = 0;
        release_wait = 0;
        ack_q        = 1'b0;
        rst_q        = 1'b1;
        result_q     = '0;
        wait (rst == 1'b0);
        run_test(1, 0, "clean words");
        run_test(2, 1, "single errors");
        run_test(3, 2, "double errors");
        run_test(4, 3, "triple errors");
        $display("test 5 handshake rules: %0d errors", hs_errors);
        $display("checked %0d words in %0d cycles, %0d errors", checks, cycles,
                 errors + hs_errors);
        if (errors + hs_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (5) @(posedge clk);   // reset held for 5 cycles
        rst <= 1'b0;
    end

    always #4 clk = ~clk;   // 8 ns period

endmodule

`default_nettype wire
